// ==== files.f ====
rtl/hmc_pkg.sv
rtl/flit_bus_pkg.sv
rtl/link_start_delay.sv
rtl/req_flit_builder.sv
rtl/rsp_flit_parser.sv
rtl/flit_gen_top.sv
sim/flit_gen_sva.sv
sim/flit_gen_tb.sv

// ==== Bender.yml ====
package:
  name: flit_gen

sources:
  - rtl/hmc_pkg.sv
  - rtl/flit_bus_pkg.sv
  - rtl/link_start_delay.sv
  - rtl/req_flit_builder.sv
  - rtl/rsp_flit_parser.sv
  - rtl/flit_gen_top.sv
  - target: simulation
    files:
      - sim/flit_gen_sva.sv
      - sim/flit_gen_tb.sv

// ==== sim/flit_gen_tb.sv ====
// Runs the default 256-cycle start delay with init_done_i high from reset release; stops at first error
`default_nettype none

module flit_gen_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic         CLK;
  logic         RST;
  logic         init_done_i;
  logic         wr_req_i;
  logic         rd_req_i;
  logic [33:0]  wr_addr_i;
  logic [33:0]  rd_addr_i;
  logic [255:0] wr_data_i;
  logic         tx_tvalid_o;
  logic         tx_tready_i;
  logic [511:0] tx_tdata;
  logic [63:0]  tx_tuser;
  logic         rx_tvalid_i;
  logic         rx_tready_o;
  logic [511:0] rx_tdata_i;
  logic [63:0]  rx_tuser_i;
  logic         rsp_valid_o;
  logic [255:0] rsp_data_o;
  logic [8:0]   rsp_tag_o;
  logic [63:0]  rsp_cnt_o;

  int           seed = 51;
  int           i;
  logic [33:0]  addr;
  logic [255:0] data;
  logic [511:0] exp_word;

  flit_gen_top i_dut (
    .CLK         (CLK),
    .RST         (RST),
    .init_done_i (init_done_i),
    .wr_req_i    (wr_req_i),
    .rd_req_i    (rd_req_i),
    .wr_addr_i   (wr_addr_i),
    .rd_addr_i   (rd_addr_i),
    .wr_data_i   (wr_data_i),
    .tx_tvalid_o (tx_tvalid_o),
    .tx_tready_i (tx_tready_i),
    .tx_tdata_o  (tx_tdata),
    .tx_tuser_o  (tx_tuser),
    .rx_tvalid_i (rx_tvalid_i),
    .rx_tready_o (rx_tready_o),
    .rx_tdata_i  (rx_tdata_i),
    .rx_tuser_i  (rx_tuser_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_tag_o   (rsp_tag_o),
    .rsp_cnt_o   (rsp_cnt_o)
  );

  // 8 ns period
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // ----------------------------------------
  // Reporting
  // ----------------------------------------
  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // Bound assertions count their failures
  always @(negedge CLK) begin
    if (i_dut.i_sva.fail_cnt != 0) begin
      $display("A bound protocol assertion failed at %0t ns", $time);
      abort_run();
    end
  end

  // ----------------------------------------
  // Reference packet builders
  // ----------------------------------------

  // Fields top down as cube, reserved, address, tag, dln, lng, reserved and command
  function automatic logic [63:0] make_hdr(input logic [5:0] cmd, input logic [3:0] lng,
                                           input logic [33:0] adr, input logic [8:0] tag);
    make_hdr = {3'd0, 3'd0, adr, tag, lng, lng, 1'b0, cmd};
  endfunction

  function automatic logic [33:0] rand_addr();
    logic [63:0] val;
    val = {$random(seed), $random(seed)};
    return val[33:0];
  endfunction

  function automatic logic [255:0] rand_data();
    logic [255:0] val;
    for (int k = 0; k < 8; k++) begin
      val[32*k +: 32] = $random(seed);
    end
    return val;
  endfunction

  // Response pulse arrives one cycle after its last beat
  task automatic wait_rsp(input int limit);
    int cnt;
    cnt = 0;
    while (!rsp_valid_o) begin
      if (cnt == limit) begin
        $display("Timeout after %0d cycles waiting for rsp_valid_o", limit);
        abort_run();
      end
      @(negedge CLK);
      cnt++;
    end
  endtask

  // RD32 with tx_tready_i already high is taken on the edge after it shows
  task automatic send_read(input logic [8:0] tag);
    logic [33:0]  adr;
    logic [511:0] exp;
    adr = rand_addr();
    exp = {448'd0, make_hdr(6'b110001, 4'd1, adr, tag)};
    rd_addr_i = adr;
    rd_req_i  = 1'b1;
    @(negedge CLK);
    rd_req_i = 1'b0;
    // Header and tail in slot 0, only slot 0 valid
    assert (tx_tvalid_o && tx_tdata == exp && tx_tuser == 64'h111)
      else report_error($sformatf("RD32 word wrong for tag %0d", tag));
    @(negedge CLK);
    assert (!tx_tvalid_o) else report_error("RD32 word not taken by the stream");
  endtask

  // Packet of header, 256 data bits and tail starting at the given slot
  task automatic send_rsp(input int slot, input logic [8:0] tag);
    logic [255:0]  dat;
    logic [1023:0] stream;
    logic [7:0]    head;
    logic [7:0]    tail;
    logic [7:0]    vld;
    dat    = rand_data();
    // 6'b111000 is RD_RS
    stream = {640'd0, 64'd0, dat, make_hdr(6'b111000, 4'd3, 34'd0, tag)} << (128 * slot);
    // Flag masks over two beats of four slots each
    head = 8'd1 << slot;
    tail = 8'd1 << (slot + 2);
    vld  = 8'd7 << slot;
    rx_tvalid_i = 1'b1;
    rx_tdata_i  = stream[511:0];
    rx_tuser_i  = {52'd0, tail[3:0], head[3:0], vld[3:0]};
    @(negedge CLK);
    if (slot >= 2) begin
      assert (!rsp_valid_o) else report_error("Split response reported after one beat");
      rx_tdata_i = stream[1023:512];
      rx_tuser_i = {52'd0, tail[7:4], head[7:4], vld[7:4]};
      @(negedge CLK);
    end
    rx_tvalid_i = 1'b0;
    wait_rsp(4);
    assert (rsp_data_o == dat && rsp_tag_o == tag)
      else report_error($sformatf("Response data or tag wrong, header in slot %0d", slot));
    @(negedge CLK);
    assert (!rsp_valid_o) else report_error("rsp_valid_o high for more than one cycle");
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    RST         = 1'b1;
    init_done_i = 1'b0;
    wr_req_i    = 1'b0;
    rd_req_i    = 1'b0;
    wr_addr_i   = '0;
    rd_addr_i   = '0;
    wr_data_i   = '0;
    tx_tready_i = 1'b0;
    rx_tvalid_i = 1'b0;
    rx_tdata_i  = '0;
    rx_tuser_i  = '0;
    repeat (4) @(negedge CLK);
    RST         = 1'b0;
    init_done_i = 1'b1;

    // Strobes during the settle delay must not produce a word
    wr_req_i    = 1'b1;
    rd_req_i    = 1'b1;

    // Both streams quiet through the settle delay
    for (i = 0; i < 256; i++) begin
      @(negedge CLK);
      assert (!tx_tvalid_o && !rx_tready_o) else report_error("Stream active before start");
    end
    wr_req_i = 1'b0;
    rd_req_i = 1'b0;
    @(negedge CLK);
    assert (rx_tready_o) else report_error("rx_tready_o still low after start");

    // P_WR32 under back-pressure
    addr      = rand_addr();
    data      = rand_data();
    exp_word  = {192'd0, data, make_hdr(6'b011001, 4'd3, addr, 9'd0)};
    wr_addr_i = addr;
    wr_data_i = data;
    wr_req_i  = 1'b1;
    @(negedge CLK);
    wr_req_i  = 1'b0;
    // Read strobe while the write is pending must be dropped
    rd_addr_i = rand_addr();
    rd_req_i  = 1'b1;
    for (i = 0; i < 5; i++) begin
      // Tail in slot 2, header in slot 0, all slots valid
      assert (tx_tvalid_o && tx_tdata == exp_word && tx_tuser == 64'h41F)
        else report_error("P_WR32 word wrong or not held under back-pressure");
      @(negedge CLK);
      rd_req_i = 1'b0;
    end
    tx_tready_i = 1'b1;
    @(negedge CLK);
    assert (!tx_tvalid_o) else report_error("P_WR32 word not taken by the stream");

    // Dropped strobes left the tag at 1
    send_read(9'd1);
    send_read(9'd2);
    send_read(9'd3);

    // One response per header slot
    for (i = 0; i < 4; i++) begin
      send_rsp(i, 9'(i + 20));
    end

    // Slot 3 header, foreign beat, then a late continuation
    rx_tvalid_i = 1'b1;
    rx_tdata_i  = {rand_data(), rand_data()};
    rx_tdata_i[447:384] = make_hdr(6'b111000, 4'd3, 34'd0, 9'd7);
    rx_tuser_i  = {52'd0, 4'b0000, 4'b1000, 4'b1000};
    @(negedge CLK);
    rx_tdata_i  = {rand_data(), rand_data()};
    rx_tuser_i  = {52'd0, 12'h00F};
    @(negedge CLK);
    rx_tuser_i  = {52'd0, 4'b0010, 4'b0000, 4'b0011};
    @(negedge CLK);
    rx_tvalid_i = 1'b0;
    for (i = 0; i < 4; i++) begin
      assert (!rsp_valid_o) else report_error("Discarded partial response was reported");
      @(negedge CLK);
    end
    assert (rsp_cnt_o == 64'd4)
      else report_error($sformatf("rsp_cnt_o is %0d, expected 4", rsp_cnt_o));

    if (i_dut.i_sva.fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== sim/flit_gen_sva.sv ====
// Bound into flit_gen_top; relies on start never falling between resets
`default_nettype none

module flit_gen_sva (
  input wire                            CLK,
  input wire                            RST,
  input wire                            start_i,
  input wire                            tx_tvalid_i,
  input wire                            tx_tready_i,
  input wire flit_bus_pkg::flit_word_t  tx_tdata_i,
  input wire flit_bus_pkg::flit_user_t  tx_tuser_i,
  input wire                            rx_tready_i,
  input wire                            rsp_valid_i,
  input wire [63:0]                     rsp_cnt_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Read by the testbench
  int fail_cnt = 0;

  // ----------------------------------------
  // TX stream
  // ----------------------------------------

  // Pending word holds until taken
  tx_hold: assert property (@(posedge CLK) disable iff (RST)
    (tx_tvalid_i && !tx_tready_i) |=>
      (tx_tvalid_i && $stable(tx_tdata_i) && $stable(tx_tuser_i)))
    else begin
      $error("TX word changed or dropped under back-pressure");
      fail_cnt++;
    end

  // Both streams idle until the settle delay ends
  quiet_before_start: assert property (@(posedge CLK) disable iff (RST)
    !start_i |-> (!tx_tvalid_i && !rx_tready_i))
    else begin
      $error("Stream handshake active before start");
      fail_cnt++;
    end

  // ----------------------------------------
  // Response counter
  // ----------------------------------------
  cnt_step: assert property (@(posedge CLK) disable iff (RST)
    rsp_valid_i |-> (rsp_cnt_i == $past(rsp_cnt_i) + 64'd1))
    else begin
      $error("rsp_cnt_o did not step with rsp_valid_o");
      fail_cnt++;
    end

  cnt_hold: assert property (@(posedge CLK) disable iff (RST)
    !rsp_valid_i |-> $stable(rsp_cnt_i))
    else begin
      $error("rsp_cnt_o changed without rsp_valid_o");
      fail_cnt++;
    end

endmodule

bind flit_gen_top flit_gen_sva i_sva (
  .CLK         (CLK),
  .RST         (RST),
  .start_i     (start),
  .tx_tvalid_i (tx_tvalid_o),
  .tx_tready_i (tx_tready_i),
  .tx_tdata_i  (tx_tdata_o),
  .tx_tuser_i  (tx_tuser_o),
  .rx_tready_i (rx_tready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_cnt_i   (rsp_cnt_o)
);

`default_nettype wire

// ==== rtl/flit_gen_top.sv ====
// One HMC link only; TX and RX ports follow the openHMC AXI-stream layout with four FLITs per word
`default_nettype none

module flit_gen_top #(
  parameter int unsigned INIT_WAIT_LOG2 = 8
) (
  input  wire                            CLK,
  input  wire                            RST,

  // ----------------------------------------
  // Controller side
  // ----------------------------------------
  input  wire                            init_done_i,
  input  wire                            wr_req_i,
  input  wire                            rd_req_i,
  input  wire hmc_pkg::hmc_addr_t        wr_addr_i,
  input  wire hmc_pkg::hmc_addr_t        rd_addr_i,
  input  wire hmc_pkg::hmc_data_t        wr_data_i,

  // TX stream towards openHMC
  output logic                           tx_tvalid_o,
  input  wire                            tx_tready_i,
  output flit_bus_pkg::flit_word_t       tx_tdata_o,
  output flit_bus_pkg::flit_user_t       tx_tuser_o,

  // RX stream from openHMC
  input  wire                            rx_tvalid_i,
  output logic                           rx_tready_o,
  input  wire flit_bus_pkg::flit_word_t  rx_tdata_i,
  input  wire flit_bus_pkg::flit_user_t  rx_tuser_i,

  // Recovered read responses
  output logic                           rsp_valid_o,
  output hmc_pkg::hmc_data_t             rsp_data_o,
  output hmc_pkg::hmc_tag_t              rsp_tag_o,
  output logic [63:0]                    rsp_cnt_o
);

  // Shared go level for both directions
  logic start;

  link_start_delay #(
    .INIT_WAIT_LOG2 (INIT_WAIT_LOG2)
  ) i_start_delay (
    .CLK         (CLK),
    .RST         (RST),
    .init_done_i (init_done_i),
    .start_o     (start)
  );

  // Request side
  req_flit_builder i_req_builder (
    .CLK         (CLK),
    .RST         (RST),
    .start_i     (start),
    .wr_req_i    (wr_req_i),
    .rd_req_i    (rd_req_i),
    .wr_addr_i   (wr_addr_i),
    .rd_addr_i   (rd_addr_i),
    .wr_data_i   (wr_data_i),
    .tx_tready_i (tx_tready_i),
    .tx_tvalid_o (tx_tvalid_o),
    .tx_tdata_o  (tx_tdata_o),
    .tx_tuser_o  (tx_tuser_o)
  );

  // Response side
  rsp_flit_parser i_rsp_parser (
    .CLK         (CLK),
    .RST         (RST),
    .start_i     (start),
    .rx_tvalid_i (rx_tvalid_i),
    .rx_tdata_i  (rx_tdata_i),
    .rx_tuser_i  (rx_tuser_i),
    .rx_tready_o (rx_tready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_tag_o   (rsp_tag_o),
    .rsp_cnt_o   (rsp_cnt_o)
  );

endmodule

`default_nettype wire

// ==== rtl/rsp_flit_parser.sv ====
// Accepts only headers with the 32-byte read response length and no back-pressure is applied once started
`default_nettype none

module rsp_flit_parser (
  input  wire                            CLK,
  input  wire                            RST,
  input  wire                            start_i,
  input  wire                            rx_tvalid_i,
  input  wire flit_bus_pkg::flit_word_t  rx_tdata_i,
  input  wire flit_bus_pkg::flit_user_t  rx_tuser_i,
  output logic                           rx_tready_o,
  output logic                           rsp_valid_o,
  output hmc_pkg::hmc_data_t             rsp_data_o,
  output hmc_pkg::hmc_tag_t              rsp_tag_o,
  output logic [63:0]                    rsp_cnt_o
);

  import hmc_pkg::*;
  import flit_bus_pkg::*;

  // Word transferred this edge
  logic         beat;
  flit_flags_t  flags;
  // Header of the slot the head mask points at
  hmc_hdr_t     hdr;
  logic         hdr_ok;

  // Response finished by this word
  logic         done;
  hmc_data_t    done_data;
  hmc_tag_t     done_tag;

  // First half of a straddling response
  logic         split;
  logic         split_s3;
  logic [191:0] split_data;

  // Partial response waiting for its second beat
  logic         part_q;
  // Header was in slot 3 rather than slot 2
  logic         part_s3_q;
  logic [191:0] part_data_q;
  hmc_tag_t     part_tag_q;

  assign beat  = rx_tvalid_i && rx_tready_o;
  assign flags = rx_tuser_i[FLAGS_W-1:0];

  // ----------------------------------------
  // Slot decode
  // ----------------------------------------
  always_comb begin
    done       = 1'b0;
    done_data  = '0;
    done_tag   = part_tag_q;
    split      = 1'b0;
    split_s3   = 1'b0;
    split_data = '0;

    // Continuation beats must match the expected layout exactly
    if (part_q && !part_s3_q && flags == FLAGS_RS_CONT2) begin
      done      = 1'b1;
      // Last 64 data bits in the low half of slot 0
      done_data = {rx_tdata_i[0].raw[63:0], part_data_q};
    end
    if (part_q && part_s3_q && flags == FLAGS_RS_CONT3) begin
      done      = 1'b1;
      // 192 data bits in slots 0 and 1
      done_data = {rx_tdata_i[1].raw[63:0], rx_tdata_i[0].raw, part_data_q[63:0]};
    end

    // Pick the header view of the marked slot
    case (flags.head)
      SLOT_0:  hdr = rx_tdata_i[0].ht.hdr;
      SLOT_1:  hdr = rx_tdata_i[1].ht.hdr;
      SLOT_2:  hdr = rx_tdata_i[2].ht.hdr;
      SLOT_3:  hdr = rx_tdata_i[3].ht.hdr;
      default: hdr = '0;
    endcase
    // Zero header fails this too
    hdr_ok = (hdr.lng == LNG_RD_RS32);

    if (hdr_ok) begin
      case (flags.head)
        // Whole response inside this word
        SLOT_0: begin
          done      = 1'b1;
          done_tag  = hdr.tag;
          done_data = {rx_tdata_i[2].raw[63:0], rx_tdata_i[1].raw, rx_tdata_i[0].raw[127:64]};
        end
        SLOT_1: begin
          done      = 1'b1;
          done_tag  = hdr.tag;
          done_data = {rx_tdata_i[3].raw[63:0], rx_tdata_i[2].raw, rx_tdata_i[1].raw[127:64]};
        end
        // Low 192 data bits now
        SLOT_2: begin
          split      = 1'b1;
          split_data = {rx_tdata_i[3].raw, rx_tdata_i[2].raw[127:64]};
        end
        // Low 64 data bits now
        SLOT_3: begin
          split      = 1'b1;
          split_s3   = 1'b1;
          split_data = {128'd0, rx_tdata_i[3].raw[127:64]};
        end
        default: begin
          split = 1'b0;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Control state and counter
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      rx_tready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_cnt_o   <= '0;
      part_q      <= 1'b0;
      part_s3_q   <= 1'b0;
    end else begin
      // start_i never falls, so ready stays up
      rx_tready_o <= start_i;
      rsp_valid_o <= beat && done;
      if (beat && done) begin
        rsp_cnt_o <= rsp_cnt_o + 64'd1;
      end
      // Any valid beat ends a partial response, finished or not
      if (beat) begin
        part_q <= split;
        if (split) begin
          part_s3_q <= split_s3;
        end
      end
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    if (beat && done) begin
      rsp_data_o <= done_data;
      rsp_tag_o  <= done_tag;
    end
    if (beat && split) begin
      part_data_q <= split_data;
      part_tag_q  <= hdr.tag;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/req_flit_builder.sv ====
// One word in flight at a time; strobes while a word is pending are dropped and a write wins over a read
`default_nettype none

module req_flit_builder (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       start_i,
  input  wire                       wr_req_i,
  input  wire                       rd_req_i,
  input  wire hmc_pkg::hmc_addr_t   wr_addr_i,
  input  wire hmc_pkg::hmc_addr_t   rd_addr_i,
  input  wire hmc_pkg::hmc_data_t   wr_data_i,
  input  wire                       tx_tready_i,
  output logic                      tx_tvalid_o,
  output flit_bus_pkg::flit_word_t  tx_tdata_o,
  output flit_bus_pkg::flit_user_t  tx_tuser_o
);

  import hmc_pkg::*;
  import flit_bus_pkg::*;

  // Request accepted this edge
  logic        accept;
  hmc_hdr_t    req_hdr;
  flit_word_t  req_word;
  flit_flags_t req_flags;
  // Next read tag
  hmc_tag_t    tag_q;
  flit_flags_t flags_q;

  // Only while idle and after the settle delay
  assign accept = start_i && !tx_tvalid_o && (wr_req_i || rd_req_i);

  // ----------------------------------------
  // Header and slot packing
  // ----------------------------------------
  always_comb begin
    req_hdr = '0;
    if (wr_req_i) begin
      req_hdr.cmd  = CMD_P_WR32;
      req_hdr.lng  = LNG_WR32;
      req_hdr.dln  = LNG_WR32;
      req_hdr.addr = wr_addr_i;
      // Posted writes need no tag
      req_hdr.tag  = '0;
    end else begin
      req_hdr.cmd  = CMD_RD32;
      req_hdr.lng  = LNG_RD32;
      req_hdr.dln  = LNG_RD32;
      req_hdr.addr = rd_addr_i;
      req_hdr.tag  = tag_q;
    end

    // Unused slots stay zero as NULL padding
    req_word = '0;
    req_word[0].ht.hdr = req_hdr;
    if (wr_req_i) begin
      // Data runs from bit 64 of the word up to bit 319
      req_word[0].raw[127:64] = wr_data_i[63:0];
      req_word[1].raw         = wr_data_i[191:64];
      req_word[2].raw[63:0]   = wr_data_i[255:192];
      // Tail left zero, the controller fills CRC and sequence
      req_word[2].ht.tail     = '0;
      req_flags = FLAGS_WR32;
    end else begin
      // Read tail shares slot 0 with the header
      req_word[0].ht.tail = '0;
      req_flags = FLAGS_RD32;
    end
  end

  // ----------------------------------------
  // Pending word and tag
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      tx_tvalid_o <= 1'b0;
      tag_q       <= 9'd1;
    end else begin
      if (accept) begin
        tx_tvalid_o <= 1'b1;
      end else if (tx_tvalid_o && tx_tready_i) begin
        // Word taken by the controller
        tx_tvalid_o <= 1'b0;
      end
      // Tags advance on reads only
      if (accept && !wr_req_i) begin
        tag_q <= tag_q + 1'b1;
      end
    end
  end

  // Held steady under back-pressure
  always_ff @(posedge CLK) begin
    if (accept) begin
      tx_tdata_o <= req_word;
      flags_q    <= req_flags;
    end
  end

  // Upper TUSER bits unused
  assign tx_tuser_o = {{(TUSER_W - FLAGS_W){1'b0}}, flags_q};

endmodule

`default_nettype wire

// ==== rtl/link_start_delay.sv ====
// Counts only while init_done_i is high and never drops start_o again until RST
`default_nettype none

module link_start_delay #(
  parameter int unsigned INIT_WAIT_LOG2 = 8
) (
  input  wire  CLK,
  input  wire  RST,
  input  wire  init_done_i,
  output logic start_o
);

  // ----------------------------------------
  // Settle counter
  // ----------------------------------------

  // One extra bit, the top bit is the start flag
  logic [INIT_WAIT_LOG2:0] wait_cnt_q;

  // Lets the controller finish its NULL FLITs before traffic starts
  always_ff @(posedge CLK) begin
    if (RST) begin
      wait_cnt_q <= '0;
    end else if (init_done_i && !wait_cnt_q[INIT_WAIT_LOG2]) begin
      // Freezes once the top bit sets
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  // High from the edge where the count reaches 2**INIT_WAIT_LOG2
  assign start_o = wait_cnt_q[INIT_WAIT_LOG2];

endmodule

`default_nettype wire

// ==== rtl/flit_bus_pkg.sv ====
// Fixed at four FLITs per AXI-stream word; TUSER carries only the 12 flag bits and the rest is zero
`default_nettype none

package flit_bus_pkg;

  // ----------------------------------------
  // Word layout
  // ----------------------------------------

  // The slot-packing cases assume exactly four slots
  localparam int unsigned FPW     = 4;
  // 16 TUSER bits per FLIT
  localparam int unsigned TUSER_W = 16 * FPW;

  // Slot 0 in the low bits is processed first
  typedef hmc_pkg::hmc_flit_u [FPW-1:0] flit_word_t;

  typedef logic [TUSER_W-1:0] flit_user_t;

  // One bit per slot
  typedef logic [FPW-1:0] flit_mask_t;

  // Flag masks in the low TUSER bits
  typedef struct packed {
    flit_mask_t tail;
    flit_mask_t head;
    flit_mask_t valid;
  } flit_flags_t;

  localparam int unsigned FLAGS_W = $bits(flit_flags_t);

  // ----------------------------------------
  // Slot masks and flag patterns
  // ----------------------------------------
  localparam flit_mask_t SLOT_0 = 4'b0001;
  localparam flit_mask_t SLOT_1 = 4'b0010;
  localparam flit_mask_t SLOT_2 = 4'b0100;
  localparam flit_mask_t SLOT_3 = 4'b1000;

  // P_WR32 fills the word, slot 3 is padding
  localparam flit_flags_t FLAGS_WR32 = '{tail: SLOT_2, head: SLOT_0, valid: '1};
  // RD32 sits alone in slot 0
  localparam flit_flags_t FLAGS_RD32 = '{tail: SLOT_0, head: SLOT_0, valid: SLOT_0};

  // Second beat of a response whose header was in slot 2
  localparam flit_flags_t FLAGS_RS_CONT2 = '{tail: SLOT_0, head: '0, valid: SLOT_0};
  // Second beat of a response whose header was in slot 3
  localparam flit_flags_t FLAGS_RS_CONT3 = '{tail: SLOT_1, head: '0, valid: SLOT_0 | SLOT_1};

endpackage

`default_nettype wire

// ==== rtl/hmc_pkg.sv ====
// Describes only the 32-byte write, read and read response packets and leaves tail fields to the controller
`default_nettype none

package hmc_pkg;

  // ----------------------------------------
  // Field types
  // ----------------------------------------

  // Request address as carried in the header
  typedef logic [33:0] hmc_addr_t;

  // Tag that pairs a read with its response
  typedef logic [8:0] hmc_tag_t;

  // Payload of one 32-byte access
  typedef logic [255:0] hmc_data_t;

  // ----------------------------------------
  // Header layout
  // ----------------------------------------

  // Same layout for request and response headers
  // Top bit first
  typedef struct packed {
    logic [2:0] cub;
    logic [2:0] res_hi;
    hmc_addr_t  addr;
    hmc_tag_t   tag;
    // Copy of lng
    logic [3:0] dln;
    // Packet length in FLITs, header and tail included
    logic [3:0] lng;
    logic       res_lo;
    logic [5:0] cmd;
  } hmc_hdr_t;

  // Header in the low half and tail in the high half
  typedef struct packed {
    logic [63:0] tail;
    hmc_hdr_t    hdr;
  } hmc_ht_t;

  // One 128-bit FLIT seen as header and tail or as plain data
  typedef union packed {
    hmc_ht_t      ht;
    logic [127:0] raw;
  } hmc_flit_u;

  // ----------------------------------------
  // Commands and lengths
  // ----------------------------------------

  // Posted write, no response comes back
  localparam logic [5:0] CMD_P_WR32 = 6'b011001;
  localparam logic [5:0] CMD_RD32   = 6'b110001;

  // Header, two data FLITs and tail
  localparam logic [3:0] LNG_WR32    = 4'd3;
  // Header and tail share one FLIT
  localparam logic [3:0] LNG_RD32    = 4'd1;
  localparam logic [3:0] LNG_RD_RS32 = 4'd3;

endpackage

`default_nettype wire
